/* axi_btn_pkg.sv */
package axi_btn_pkg;

    // AXI field widths
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] data_t;    // one data word
    typedef logic [1:0]  id_t;
    typedef logic [7:0]  len_t;     // beats minus one
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  strb_t;    // one bit per byte lane

    typedef logic [3:0]  btn_t;     // push buttons, one per command

    // per-channel handshake machine
    typedef enum logic {
        CH_IDLE = 1'b0,             // nothing offered
        CH_TRAN = 1'b1              // valid up, waiting for ready
    } chan_state_e;

    // fixed encodings from the AXI spec
    localparam burst_t BURST_INCR = 2'b01;
    localparam resp_t  RESP_OKAY  = 2'b00;

endpackage

/* axi_btn_master.sv */
`timescale 1ns/1ps

module axi_btn_master #(
    parameter axi_btn_pkg::addr_t TARGET_ADDR = 32'h2000_0000
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  axi_btn_pkg::btn_t    btn,
    output axi_btn_pkg::data_t   recv_data,
    output logic                 busy,

    output axi_btn_pkg::id_t     aw_id,
    output axi_btn_pkg::addr_t   aw_addr,
    output axi_btn_pkg::len_t    aw_len,
    output axi_btn_pkg::burst_t  aw_burst,
    output logic                 aw_valid,
    input  logic                 aw_ready,

    output axi_btn_pkg::data_t   w_data,
    output axi_btn_pkg::strb_t   w_strb,
    output logic                 w_last,
    output logic                 w_valid,
    input  logic                 w_ready,

    input  axi_btn_pkg::id_t     b_id,
    input  axi_btn_pkg::resp_t   b_resp,
    input  logic                 b_valid,
    output logic                 b_ready,

    output axi_btn_pkg::id_t     ar_id,
    output axi_btn_pkg::addr_t   ar_addr,
    output axi_btn_pkg::len_t    ar_len,
    output axi_btn_pkg::burst_t  ar_burst,
    output logic                 ar_valid,
    input  logic                 ar_ready,

    input  axi_btn_pkg::id_t     r_id,
    input  axi_btn_pkg::data_t   r_data,
    input  axi_btn_pkg::resp_t   r_resp,
    input  logic                 r_last,
    input  logic                 r_valid,
    output logic                 r_ready
);
    import axi_btn_pkg::*;

    localparam id_t  MST_ID   = '0;     // all traffic on one id
    localparam len_t ONE_BEAT = '0;

    btn_t        btn_s0;
    btn_t        btn_s1;
    btn_t        btn_prev;
    btn_t        btn_neg;               // one-cycle release pulse

    chan_state_e aw_state;
    chan_state_e w_state;
    chan_state_e ar_state;

    data_t       wr_count;
    logic        aw_sent;
    logic        w_sent;
    logic        rd_wait;

    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        b_done;
    logic        r_done;

    function automatic chan_state_e chan_next(chan_state_e cur, logic start, logic fire);
        chan_state_e nxt;
        nxt = cur;
        case (cur)
            CH_IDLE: if (start) nxt = CH_TRAN;
            CH_TRAN: if (fire) nxt = CH_IDLE;
            default: nxt = CH_IDLE;
        endcase
        return nxt;
    endfunction

    // two-flop sync then edge register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            btn_s0   <= '0;
            btn_s1   <= '0;
            btn_prev <= '0;
        end else begin
            btn_s0   <= btn;
            btn_s1   <= btn_s0;
            btn_prev <= btn_s1;
        end
    end

    assign btn_neg = btn_prev & ~btn_s1;

    assign aw_hs  = aw_valid & aw_ready;
    assign w_hs   = w_valid & w_ready & w_last;
    assign ar_hs  = ar_valid & ar_ready;
    // an error response leaves busy stuck high
    assign b_done = b_valid & b_ready & (b_id == MST_ID) & (b_resp == RESP_OKAY);
    assign r_done = r_valid & r_ready & r_last & (r_id == MST_ID) & (r_resp == RESP_OKAY);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_state <= CH_IDLE;
            w_state  <= CH_IDLE;
            ar_state <= CH_IDLE;
        end else begin
            aw_state <= chan_next(aw_state, btn_neg[0], aw_hs);
            w_state  <= chan_next(w_state, btn_neg[1], w_hs);
            ar_state <= chan_next(ar_state, btn_neg[2], ar_hs);
        end
    end

    // counter only moves while W is idle, so w_data holds during valid
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_count <= '0;
        end else if (w_state == CH_IDLE) begin
            if (btn_neg[3]) begin
                wr_count <= '0;
            end else if (btn_neg[1]) begin
                wr_count <= wr_count + 1'b1;    // new value goes out on W
            end
        end
    end

    // outstanding write halves and read
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            aw_sent <= (aw_sent & ~b_done) | aw_hs;
            w_sent  <= (w_sent & ~b_done) | w_hs;
            rd_wait <= (rd_wait & ~r_done) | ar_hs;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            recv_data <= '0;
        end else if (r_done) begin
            recv_data <= r_data;
        end
    end

    assign busy = (aw_state == CH_TRAN) | (w_state == CH_TRAN) | (ar_state == CH_TRAN)
                | (aw_sent & w_sent)    // B still owed
                | rd_wait;

    assign aw_id    = MST_ID;
    assign aw_addr  = TARGET_ADDR;
    assign aw_len   = ONE_BEAT;
    assign aw_burst = BURST_INCR;
    assign aw_valid = (aw_state == CH_TRAN);

    assign w_data   = wr_count;
    assign w_strb   = '1;               // full word every beat
    assign w_last   = 1'b1;
    assign w_valid  = (w_state == CH_TRAN);

    assign b_ready  = 1'b1;

    assign ar_id    = MST_ID;
    assign ar_addr  = TARGET_ADDR;
    assign ar_len   = ONE_BEAT;
    assign ar_burst = BURST_INCR;
    assign ar_valid = (ar_state == CH_TRAN);

    assign r_ready  = 1'b1;

endmodule

/* axi_word_slave.sv */
`timescale 1ns/1ps

module axi_word_slave #(
    parameter int READY_LAT = 2,        // cycles of valid before ready
    parameter int DEPTH     = 16        // words
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  axi_btn_pkg::id_t     aw_id,
    input  axi_btn_pkg::addr_t   aw_addr,
    input  axi_btn_pkg::len_t    aw_len,
    input  axi_btn_pkg::burst_t  aw_burst,
    input  logic                 aw_valid,
    output logic                 aw_ready,

    input  axi_btn_pkg::data_t   w_data,
    input  axi_btn_pkg::strb_t   w_strb,
    input  logic                 w_last,
    input  logic                 w_valid,
    output logic                 w_ready,

    output axi_btn_pkg::id_t     b_id,
    output axi_btn_pkg::resp_t   b_resp,
    output logic                 b_valid,
    input  logic                 b_ready,

    input  axi_btn_pkg::id_t     ar_id,
    input  axi_btn_pkg::addr_t   ar_addr,
    input  axi_btn_pkg::len_t    ar_len,
    input  axi_btn_pkg::burst_t  ar_burst,
    input  logic                 ar_valid,
    output logic                 ar_ready,

    output axi_btn_pkg::id_t     r_id,
    output axi_btn_pkg::data_t   r_data,
    output axi_btn_pkg::resp_t   r_resp,
    output logic                 r_last,
    output logic                 r_valid,
    input  logic                 r_ready
);
    import axi_btn_pkg::*;

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(READY_LAT + 2);
    localparam logic [CW-1:0] LAT = CW'(READY_LAT);
    localparam int NB = $bits(strb_t);

    data_t          mem [DEPTH];

    logic [CW-1:0]  aw_cnt;
    logic [CW-1:0]  w_cnt;
    logic [CW-1:0]  ar_cnt;
    logic           aw_wait;
    logic           w_wait;
    logic           ar_wait;

    logic           aw_held;            // address parked until commit
    logic           w_held;             // data parked until commit
    logic           commit;

    logic [IW-1:0]  wr_idx;
    id_t            wr_id;
    logic           aw_ok;              // single-beat INCR request
    data_t          wr_data;
    strb_t          wr_strb;
    logic           wr_last;

    chan_state_e    rd_state;
    logic           rd_ok;

    function automatic logic [IW-1:0] word_idx(addr_t a);
        return a[IW+1:2];
    endfunction

    // count up to LAT while valid waits, drop back once it stops waiting
    function automatic logic [CW-1:0] lat_step(logic [CW-1:0] cnt, logic waiting);
        logic [CW-1:0] nxt;
        nxt = '0;
        if (waiting) begin
            nxt = (cnt == LAT) ? cnt : cnt + 1'b1;
        end
        return nxt;
    endfunction

    assign aw_wait  = aw_valid & ~aw_held;
    assign w_wait   = w_valid & ~w_held;
    assign ar_wait  = ar_valid & (rd_state == CH_IDLE);

    assign aw_ready = aw_wait & (aw_cnt == LAT);
    assign w_ready  = w_wait & (w_cnt == LAT);
    assign ar_ready = ar_wait & (ar_cnt == LAT);

    assign commit   = aw_held & w_held & ~b_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_cnt  <= '0;
            w_cnt   <= '0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            aw_cnt <= lat_step(aw_cnt, aw_wait);
            w_cnt  <= lat_step(w_cnt, w_wait);
            if (aw_valid && aw_ready) begin
                aw_held <= 1'b1;
            end else if (commit) begin
                aw_held <= 1'b0;
            end
            if (w_valid && w_ready) begin
                w_held <= 1'b1;
            end else if (commit) begin
                w_held <= 1'b0;
            end
            if (commit) begin
                b_valid <= 1'b1;        // response with the write
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // parked address and data
    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            wr_idx <= word_idx(aw_addr);
            wr_id  <= aw_id;
            aw_ok  <= (aw_burst == BURST_INCR) && (aw_len == '0);
        end
        if (w_valid && w_ready) begin
            wr_data <= w_data;
            wr_strb <= w_strb;
            wr_last <= w_last;
        end
        if (commit) begin
            b_id <= wr_id;              // echo AW id on B
        end
    end

    // word RAM, byte lanes follow the strobes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (commit && aw_ok && wr_last) begin
            for (int b = 0; b < NB; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_ok = (ar_burst == BURST_INCR) && (ar_len == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_state <= CH_IDLE;
            ar_cnt   <= '0;
        end else begin
            ar_cnt <= lat_step(ar_cnt, ar_wait);
            case (rd_state)
                CH_IDLE: if (ar_valid && ar_ready) rd_state <= CH_TRAN;
                CH_TRAN: if (r_ready) rd_state <= CH_IDLE;
                default: rd_state <= CH_IDLE;
            endcase
        end
    end

    // unsupported burst shapes read back as zero
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r_id   <= ar_id;
            r_data <= rd_ok ? mem[word_idx(ar_addr)] : '0;
        end
    end

    assign r_valid = (rd_state == CH_TRAN);
    assign r_last  = 1'b1;              // single beat only
    assign r_resp  = RESP_OKAY;
    assign b_resp  = RESP_OKAY;

endmodule

/* axi_btn_top.sv */
`timescale 1ns/1ps

module axi_btn_top #(
    parameter axi_btn_pkg::addr_t TARGET_ADDR = 32'h2000_0000,
    parameter int                 READY_LAT   = 2
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  axi_btn_pkg::btn_t    btn,
    output axi_btn_pkg::data_t   recv_data,
    output logic                 busy
);
    import axi_btn_pkg::*;

    // write address
    id_t    aw_id;
    addr_t  aw_addr;
    len_t   aw_len;
    burst_t aw_burst;
    logic   aw_valid;
    logic   aw_ready;
    // write data
    data_t  w_data;
    strb_t  w_strb;
    logic   w_last;
    logic   w_valid;
    logic   w_ready;
    // write response
    id_t    b_id;
    resp_t  b_resp;
    logic   b_valid;
    logic   b_ready;
    // read address
    id_t    ar_id;
    addr_t  ar_addr;
    len_t   ar_len;
    burst_t ar_burst;
    logic   ar_valid;
    logic   ar_ready;
    // read data
    id_t    r_id;
    data_t  r_data;
    resp_t  r_resp;
    logic   r_last;
    logic   r_valid;
    logic   r_ready;

    axi_btn_master #(
        .TARGET_ADDR (TARGET_ADDR)
    ) u_master (
        .clk (clk), .rstn (rstn), .btn (btn), .recv_data (recv_data), .busy (busy),
        .aw_id (aw_id), .aw_addr (aw_addr), .aw_len (aw_len), .aw_burst (aw_burst),
        .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
        .w_valid (w_valid), .w_ready (w_ready),
        .b_id (b_id), .b_resp (b_resp), .b_valid (b_valid), .b_ready (b_ready),
        .ar_id (ar_id), .ar_addr (ar_addr), .ar_len (ar_len), .ar_burst (ar_burst),
        .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r_id (r_id), .r_data (r_data), .r_resp (r_resp), .r_last (r_last),
        .r_valid (r_valid), .r_ready (r_ready)
    );

    axi_word_slave #(
        .READY_LAT (READY_LAT)          // back-pressure on AW, W and AR
    ) u_slave (
        .clk (clk), .rstn (rstn),
        .aw_id (aw_id), .aw_addr (aw_addr), .aw_len (aw_len), .aw_burst (aw_burst),
        .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
        .w_valid (w_valid), .w_ready (w_ready),
        .b_id (b_id), .b_resp (b_resp), .b_valid (b_valid), .b_ready (b_ready),
        .ar_id (ar_id), .ar_addr (ar_addr), .ar_len (ar_len), .ar_burst (ar_burst),
        .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r_id (r_id), .r_data (r_data), .r_resp (r_resp), .r_last (r_last),
        .r_valid (r_valid), .r_ready (r_ready)
    );

endmodule

/* axi_btn_assert.sv */
`timescale 1ns/1ps

module axi_btn_assert (
    input logic                clk,
    input logic                rstn,
    input logic                busy,
    input logic                aw_valid, aw_ready,
    input logic [43:0]         aw_bundle,      // id, addr, len, burst
    input logic                w_valid, w_ready,
    input logic [36:0]         w_bundle,       // data, strb, last
    input logic                ar_valid, ar_ready,
    input logic [43:0]         ar_bundle,
    input logic                b_valid,
    input axi_btn_pkg::resp_t  b_resp,
    input logic                r_valid,
    input axi_btn_pkg::resp_t  r_resp
);
    import axi_btn_pkg::*;

    int unsigned err_count = 0;             // failed checks so far

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_bundle)) else begin
        $error("AW valid dropped or payload changed before aw_ready");
        err_count++;
    end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w_bundle)) else begin
        $error("W valid dropped or payload changed before w_ready");
        err_count++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_bundle)) else begin
        $error("AR valid dropped or payload changed before ar_ready");
        err_count++;
    end

    // slave never signals an error
    resp_okay: assert property (@(posedge clk) disable iff (!rstn)
        (!b_valid || b_resp == RESP_OKAY) && (!r_valid || r_resp == RESP_OKAY)) else begin
        $error("response on B or R is not OKAY");
        err_count++;
    end

    idle_after_rst: assert property (@(posedge clk) $rose(rstn) |-> !busy) else begin
        $error("busy high in the first cycle after reset");
        err_count++;
    end

endmodule

/* tb_axi_btn_top.sv */
`timescale 1ns/1ps

module tb_axi_btn_top;
    import axi_btn_pkg::*;

    localparam int N_ROWS      = 21;
    localparam int BUSY_LIMIT  = 40;
    localparam int WDOG_CYCLES = N_ROWS * 60 + 200;

    logic        clk;
    logic        rstn;
    btn_t        btn;
    data_t       recv_data;
    logic        busy;

    // button per row: 0 AW, 1 W with count+1, 2 AR, 3 clear
    int    btn_seq [N_ROWS] = '{2, 0, 1, 2, 0, 1, 2, 3, 0, 1, 2,
                                1, 0, 2, 0, 1, 2, 3, 1, 0, 2};
    data_t exp_recv [N_ROWS];               // recv_data once busy is low

    axi_btn_top u_axi_btn_top (
        .clk       (clk),
        .rstn      (rstn),
        .btn       (btn),
        .recv_data (recv_data),
        .busy      (busy)
    );

    bind axi_btn_master axi_btn_assert u_assert (
        .clk (clk), .rstn (rstn), .busy (busy),
        .aw_valid (aw_valid), .aw_ready (aw_ready),
        .aw_bundle ({aw_id, aw_addr, aw_len, aw_burst}),
        .w_valid (w_valid), .w_ready (w_ready), .w_bundle ({w_data, w_strb, w_last}),
        .ar_valid (ar_valid), .ar_ready (ar_ready),
        .ar_bundle ({ar_id, ar_addr, ar_len, ar_burst}),
        .b_valid (b_valid), .b_resp (b_resp), .r_valid (r_valid), .r_resp (r_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counter, target word and read register as the buttons define them
    function automatic void fill_expected();
        data_t count   = '0;
        data_t word    = '0;
        data_t wdata   = '0;
        data_t recv    = '0;
        logic  aw_pend = 1'b0;
        logic  w_pend  = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            case (btn_seq[i])
                0: aw_pend = 1'b1;
                1: begin
                    count  = count + 1;
                    wdata  = count;
                    w_pend = 1'b1;
                end
                2: recv = word;
                default: count = '0;
            endcase
            if (aw_pend && w_pend) begin    // write pair complete
                word    = wdata;
                aw_pend = 1'b0;
                w_pend  = 1'b0;
            end
            exp_recv[i] = recv;
        end
    endfunction

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic run_row(input int row);
        int press_len;
        int gap;
        int waited;
        press_len = 2 + int'($urandom % 4);
        gap       = int'($urandom % 4);
        @(posedge clk);
        btn <= btn_t'(4'b0001 << btn_seq[row]);
        repeat (press_len) @(posedge clk);
        btn <= '0;
        repeat (3) @(posedge clk);          // sync, edge detect, FSM entry
        @(negedge clk);
        waited = 0;
        while (busy && waited < BUSY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (!busy) else begin
            $display("busy still high %0d cycles into row %0d", BUSY_LIMIT, row);
            stop_with_failure();
        end
        assert (recv_data == exp_recv[row]) else begin
            $display("FAILED at %0t: recv_data = 0x%08h, expected 0x%08h (row %0d)",
                     $time, recv_data, exp_recv[row], row);
            stop_with_failure();
        end
        repeat (gap) @(posedge clk);
    endtask

    initial begin
        void'($urandom(10));
        btn  = '0;
        rstn = 1'b0;
        fill_expected();
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!busy && recv_data == '0) else begin
            $display("FAILED at %0t: busy = %0b recv_data = 0x%08h, expected 0 and 0x00000000",
                     $time, busy, recv_data);
            stop_with_failure();
        end
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        if (u_axi_btn_top.u_master.u_assert.err_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("AXI protocol assertions failed %0d times",
                     u_axi_btn_top.u_master.u_assert.err_count);
            stop_with_failure();
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WDOG_CYCLES);
        stop_with_failure();
    end

endmodule

/* build.f */
axi_btn_pkg.sv
axi_btn_master.sv
axi_word_slave.sv
axi_btn_top.sv
axi_btn_assert.sv
tb_axi_btn_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tb_axi_btn_top \
    -o sim_tb

# keep running past assertion errors so the testbench reaches its verdict
./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
